// ==== dv/frame_input.txt ====
# verdict (1 good, 0 bad)  words  last_keep (hex)  ready_stall_pct
# stall 100 holds ready low until the sender has seen data_afull
1 1 01 0
1 8 ff 0
0 5 0f 0
1 6 3f 20
1 12 07 50
0 3 ff 50
1 128 ff 100
1 128 01 100
1 128 03 100
1 128 07 100
1 128 0f 100
1 128 1f 100
1 128 3f 100
1 128 7f 100
1 128 ff 100
1 128 01 100
1 128 03 100
1 128 07 100
1 128 0f 100
1 128 1f 100
1 128 3f 100
0 4 ff 30
1 20 7f 70
1 9 1f 40
1 2 03 0

// ==== all.f ====
src/ifm_pkg.sv
src/async_fifo.sv
src/ifm_fifo.sv
src/frame_filter.sv
src/rx_ingress_top.sv
dv/tb_rx_ingress.sv

// ==== Makefile ====
# Verilator simulation of the rx ingress buffer

VERILATOR ?= verilator
TOP       ?= tb_rx_ingress
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_rx_ingress.sv ====
module tb_rx_ingress;

   timeunit 1ns;
   timeprecision 100ps;

   import ifm_pkg::*;

   // Wait limits in clock cycles
   localparam int AFULL_TIMEOUT = 20000;
   localparam int DRAIN_TIMEOUT = 50000;

   logic              rx_clk;
   logic              s2mm_clk;
   logic              rst_n;
   logic [DATA_W-1:0] rx_data;
   logic [KEEP_W-1:0] rx_keep;
   logic              rx_last;
   logic              rx_valid;
   logic              rx_good;
   logic              data_afull;
   logic [DATA_W-1:0] mac_tdata;
   logic [KEEP_W-1:0] mac_tkeep;
   logic              mac_tlast;
   logic              mac_tvalid;
   logic              mac_tready;
   logic              good_afull;

   // Random state for the data words
   int seed = 61123;
   // Random state for the ready stalls
   int stall_seed = 61123;

   // Expected output words of good frames, one entry per word
   logic [DATA_W-1:0] exp_data[$];
   logic [KEEP_W-1:0] exp_keep[$];
   logic              exp_last[$];
   int                exp_stall[$];

   // Sender has seen data_afull high
   logic saw_afull = 1'b0;
   // Good FIFO reached its almost full level
   logic saw_good_afull = 1'b0;
   // Ends the held ready phase
   logic ready_release = 1'b0;

   rx_ingress_top uut (
      .rx_clk     (rx_clk),
      .s2mm_clk   (s2mm_clk),
      .rst_n      (rst_n),
      .rx_data    (rx_data),
      .rx_keep    (rx_keep),
      .rx_last    (rx_last),
      .rx_valid   (rx_valid),
      .rx_good    (rx_good),
      .data_afull (data_afull),
      .mac_tdata  (mac_tdata),
      .mac_tkeep  (mac_tkeep),
      .mac_tlast  (mac_tlast),
      .mac_tvalid (mac_tvalid),
      .mac_tready (mac_tready),
      .good_afull (good_afull)
   );

   initial begin
      rx_clk = 1'b0;
      forever #5 rx_clk = ~rx_clk;
   end

   initial begin
      s2mm_clk = 1'b0;
      forever #6 s2mm_clk = ~s2mm_clk;
   end

   task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("Timeout while waiting for %s", what);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   // Ready changes on the falling edge
   // a transfer is taken on the next rising edge
   initial begin : stream_sink
      int                roll;
      logic [DATA_W-1:0] want_data;
      logic [KEEP_W-1:0] want_keep;
      logic              want_last;
      mac_tready = 1'b0;
      forever begin
         @(negedge s2mm_clk);
         roll = $unsigned($random(stall_seed)) % 100;
         if (exp_data.size() == 0) begin
            // Nothing expected so any word shows up at once
            mac_tready = 1'b1;
         end else if (exp_stall[0] >= 100) begin
            // Held low to fill both FIFOs
            mac_tready = ready_release;
         end else begin
            mac_tready = (roll >= exp_stall[0]);
         end
         if (good_afull) begin
            saw_good_afull = 1'b1;
         end
         // Head word is stable here until the next rising edge
         if (rst_n && mac_tvalid && mac_tready) begin
            check_eq(64'(exp_data.size() != 0), 64'd1, "extra output word");
            want_data = exp_data.pop_front();
            want_keep = exp_keep.pop_front();
            want_last = exp_last.pop_front();
            void'(exp_stall.pop_front());
            check_eq(mac_tdata, want_data, "mac_tdata");
            check_eq(64'(mac_tkeep), 64'(want_keep), "mac_tkeep");
            check_eq(64'(mac_tlast), 64'(want_last), "mac_tlast");
         end
      end
   end

   // Reset, rx sender and end of run
   initial begin : rx_sender
      int                fd;
      int                verdict;
      int                nwords;
      int                pct;
      int                wait_cnt;
      logic [KEEP_W-1:0] last_keep;
      logic [DATA_W-1:0] word;
      string             line;
      rst_n      = 1'b0;
      rx_data    = '0;
      rx_keep    = '0;
      rx_last    = 1'b0;
      rx_valid   = 1'b0;
      rx_good    = 1'b0;
      repeat (10) @(negedge rx_clk);
      rst_n = 1'b1;
      @(negedge rx_clk);
      check_eq(64'(mac_tvalid), 64'd0, "mac_tvalid after reset");
      check_eq(64'(data_afull), 64'd0, "data_afull after reset");
      check_eq(64'(good_afull), 64'd0, "good_afull after reset");

      fd = $fopen("dv/frame_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the frame input file dv/frame_input.txt");
         $display("TEST FAILED");
         $fatal(1);
      end
      while ($fgets(line, fd) != 0) begin
         // Comment and blank lines give no fields
         if ($sscanf(line, "%d %d %h %d", verdict, nwords, last_keep, pct) == 4) begin
            // No new frame while the data FIFO is almost full
            wait_cnt = 0;
            while (data_afull) begin
               saw_afull = 1'b1;
               ready_release = 1'b1;
               wait_cnt++;
               if (wait_cnt > AFULL_TIMEOUT) begin
                  timeout_fail("data_afull to fall");
               end
               @(negedge rx_clk);
            end
            for (int w = 0; w < nwords; w++) begin
               word     = {$random(seed), $random(seed)};
               rx_data  = word;
               rx_last  = (w == nwords - 1);
               rx_keep  = rx_last ? last_keep : 8'hff;
               rx_good  = rx_last && (verdict != 0);
               rx_valid = 1'b1;
               if (verdict != 0) begin
                  exp_data.push_back(word);
                  exp_keep.push_back(rx_keep);
                  exp_last.push_back(rx_last);
                  exp_stall.push_back(pct);
               end
               @(negedge rx_clk);
            end
            rx_valid = 1'b0;
            rx_last  = 1'b0;
            rx_good  = 1'b0;
         end
      end
      $fclose(fd);
      ready_release = 1'b1;

      // Drain every expected word
      wait_cnt = 0;
      while (exp_data.size() != 0) begin
         wait_cnt++;
         if (wait_cnt > DRAIN_TIMEOUT) begin
            timeout_fail("the remaining output words");
         end
         @(negedge s2mm_clk);
      end
      // Nothing may follow the last good frame
      repeat (20) begin
         @(negedge s2mm_clk);
         check_eq(64'(mac_tvalid), 64'd0, "mac_tvalid after last frame");
      end
      check_eq(64'(saw_afull), 64'd1, "data_afull raised during held ready");
      check_eq(64'(saw_good_afull), 64'd1, "good_afull raised during held ready");
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== src/rx_ingress_top.sv ====
module rx_ingress_top #(
   parameter int DEPTH_LOG2   = ifm_pkg::DEPTH_LOG2_DEF,
   parameter int AFULL_THRESH = ifm_pkg::AFULL_DEF,
   parameter int INFO_LOG2    = ifm_pkg::INFO_LOG2_DEF
) (
   input  logic                       rx_clk,
   input  logic                       s2mm_clk,
   input  logic                       rst_n,
   input  logic [ifm_pkg::DATA_W-1:0] rx_data,
   input  logic [ifm_pkg::KEEP_W-1:0] rx_keep,
   input  logic                       rx_last,
   input  logic                       rx_valid,
   input  logic                       rx_good,
   output logic                       data_afull,
   output logic [ifm_pkg::DATA_W-1:0] mac_tdata,
   output logic [ifm_pkg::KEEP_W-1:0] mac_tkeep,
   output logic                       mac_tlast,
   output logic                       mac_tvalid,
   input  logic                       mac_tready,
   output logic                       good_afull
);

   import ifm_pkg::*;

   // FIFO block to filter
   logic [WORD_W-1:0] data_rdata;
   logic              data_empty;
   logic              info_rdata;
   logic              info_empty;

   // Filter back to FIFO block
   logic              data_rden;
   logic              info_rden;
   logic [WORD_W-1:0] good_wdata;
   logic              good_wren;

   ifm_fifo #(
      .DEPTH_LOG2   (DEPTH_LOG2),
      .AFULL_THRESH (AFULL_THRESH),
      .INFO_LOG2    (INFO_LOG2)
   ) u_ifm_fifo (
      .rx_clk     (rx_clk),
      .s2mm_clk   (s2mm_clk),
      .rst_n      (rst_n),
      .rx_data    (rx_data),
      .rx_keep    (rx_keep),
      .rx_last    (rx_last),
      .rx_valid   (rx_valid),
      .rx_good    (rx_good),
      .data_afull (data_afull),
      .data_rdata (data_rdata),
      .data_rden  (data_rden),
      .data_empty (data_empty),
      .info_rdata (info_rdata),
      .info_rden  (info_rden),
      .info_empty (info_empty),
      .good_wdata (good_wdata),
      .good_wren  (good_wren),
      .good_afull (good_afull),
      .mac_tdata  (mac_tdata),
      .mac_tkeep  (mac_tkeep),
      .mac_tlast  (mac_tlast),
      .mac_tvalid (mac_tvalid),
      .mac_tready (mac_tready)
   );

   frame_filter u_frame_filter (
      .s2mm_clk   (s2mm_clk),
      .rst_n      (rst_n),
      .data_rdata (data_rdata),
      .data_empty (data_empty),
      .data_rden  (data_rden),
      .info_rdata (info_rdata),
      .info_empty (info_empty),
      .info_rden  (info_rden),
      .good_wdata (good_wdata),
      .good_wren  (good_wren),
      .good_afull (good_afull)
   );

endmodule

// ==== src/frame_filter.sv ====
module frame_filter (
   input  logic                       s2mm_clk,
   input  logic                       rst_n,
   input  logic [ifm_pkg::WORD_W-1:0] data_rdata,
   input  logic                       data_empty,
   output logic                       data_rden,
   input  logic                       info_rdata,
   input  logic                       info_empty,
   output logic                       info_rden,
   output logic [ifm_pkg::WORD_W-1:0] good_wdata,
   output logic                       good_wren,
   input  logic                       good_afull
);

   import ifm_pkg::*;

   // State encodings
   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_COPY = 2'd1;
   localparam logic [1:0] ST_DROP = 2'd2;

   logic [1:0] state;
   logic [1:0] state_nxt;
   logic       word_last;
   logic       copy_ok;

   // Last flag of the data FIFO head
   assign word_last = data_rdata[LAST_BIT];

   // Copy needs a word and room downstream
   assign copy_ok = !data_empty && !good_afull;

   // Payload passes through unchanged
   assign good_wdata = data_rdata;

   always_comb begin
      state_nxt = state;
      data_rden = 1'b0;
      info_rden = 1'b0;
      good_wren = 1'b0;
      case (state)
         ST_IDLE: begin
            // One verdict per frame
            if (!info_empty) begin
               info_rden = 1'b1;
               state_nxt = info_rdata ? ST_COPY : ST_DROP;
            end
         end
         ST_COPY: begin
            if (copy_ok) begin
               data_rden = 1'b1;
               good_wren = 1'b1;
               if (word_last) begin
                  state_nxt = ST_IDLE;
               end
            end
         end
         ST_DROP: begin
            // Bad frame is read out and thrown away
            if (!data_empty) begin
               data_rden = 1'b1;
               if (word_last) begin
                  state_nxt = ST_IDLE;
               end
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge s2mm_clk) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Dropped frames never reach the good FIFO
   a_no_write_drop: assert property (@(posedge s2mm_clk) disable iff (!rst_n)
      (state == ST_DROP) |-> !good_wren);

endmodule

// ==== src/ifm_fifo.sv ====
module ifm_fifo #(
   parameter int DEPTH_LOG2   = ifm_pkg::DEPTH_LOG2_DEF,
   parameter int AFULL_THRESH = ifm_pkg::AFULL_DEF,
   parameter int INFO_LOG2    = ifm_pkg::INFO_LOG2_DEF
) (
   input  logic                       rx_clk,
   input  logic                       s2mm_clk,
   input  logic                       rst_n,
   input  logic [ifm_pkg::DATA_W-1:0] rx_data,
   input  logic [ifm_pkg::KEEP_W-1:0] rx_keep,
   input  logic                       rx_last,
   input  logic                       rx_valid,
   input  logic                       rx_good,
   output logic                       data_afull,
   output logic [ifm_pkg::WORD_W-1:0] data_rdata,
   input  logic                       data_rden,
   output logic                       data_empty,
   output logic                       info_rdata,
   input  logic                       info_rden,
   output logic                       info_empty,
   input  logic [ifm_pkg::WORD_W-1:0] good_wdata,
   input  logic                       good_wren,
   output logic                       good_afull,
   output logic [ifm_pkg::DATA_W-1:0] mac_tdata,
   output logic [ifm_pkg::KEEP_W-1:0] mac_tkeep,
   output logic                       mac_tlast,
   output logic                       mac_tvalid,
   input  logic                       mac_tready
);

   import ifm_pkg::*;

   logic [WORD_W-1:0] data_wdata;
   logic              info_wren;
   logic [WORD_W-1:0] good_rdata;
   logic              good_empty;
   logic              good_rden;
   logic              in_frame;

   // Pack rx beat into one FIFO word
   assign data_wdata = {rx_last, rx_keep, rx_data};

   // Verdict goes in with the last word
   assign info_wren = rx_valid && rx_last;

   async_fifo #(
      .WIDTH        (WORD_W),
      .DEPTH_LOG2   (DEPTH_LOG2),
      .AFULL_THRESH (AFULL_THRESH),
      .COMMON_CLOCK (1'b0)
   ) data_fifo (
      .wr_clk (rx_clk),
      .rd_clk (s2mm_clk),
      .rst_n  (rst_n),
      .wr_en  (rx_valid),
      .din    (data_wdata),
      .rd_en  (data_rden),
      .dout   (data_rdata),
      .full   (),
      .empty  (data_empty),
      .afull  (data_afull)
   );

   // Narrow verdict path, afull level is not used
   async_fifo #(
      .WIDTH        (1),
      .DEPTH_LOG2   (INFO_LOG2),
      .AFULL_THRESH ((1 << INFO_LOG2) - 4),
      .COMMON_CLOCK (1'b0)
   ) info_fifo (
      .wr_clk (rx_clk),
      .rd_clk (s2mm_clk),
      .rst_n  (rst_n),
      .wr_en  (info_wren),
      .din    (rx_good),
      .rd_en  (info_rden),
      .dout   (info_rdata),
      .full   (),
      .empty  (info_empty),
      .afull  ()
   );

   // Good frames only, both sides on s2mm_clk
   async_fifo #(
      .WIDTH        (WORD_W),
      .DEPTH_LOG2   (DEPTH_LOG2),
      .AFULL_THRESH (AFULL_THRESH),
      .COMMON_CLOCK (1'b1)
   ) good_fifo (
      .wr_clk (s2mm_clk),
      .rd_clk (s2mm_clk),
      .rst_n  (rst_n),
      .wr_en  (good_wren),
      .din    (good_wdata),
      .rd_en  (good_rden),
      .dout   (good_rdata),
      .full   (),
      .empty  (good_empty),
      .afull  (good_afull)
   );

   // Stream output straight off the FIFO head
   assign mac_tdata  = good_rdata[DATA_W-1:0];
   assign mac_tkeep  = good_rdata[KEEP_LSB +: KEEP_W];
   assign mac_tlast  = good_rdata[LAST_BIT];
   assign mac_tvalid = !good_empty;
   assign good_rden  = mac_tvalid && mac_tready;

   // Tracks an open rx frame for the sender check
   always_ff @(posedge rx_clk) begin
      if (!rst_n) begin
         in_frame <= 1'b0;
      end else if (rx_valid) begin
         in_frame <= !rx_last;
      end
   end

   // New frames wait until data_afull drops
   a_no_start_afull: assert property (@(posedge rx_clk) disable iff (!rst_n)
      (rx_valid && !in_frame) |-> !data_afull);

endmodule

// ==== src/async_fifo.sv ====
module async_fifo #(
   parameter int WIDTH        = ifm_pkg::WORD_W,
   parameter int DEPTH_LOG2   = ifm_pkg::DEPTH_LOG2_DEF,
   parameter int AFULL_THRESH = ifm_pkg::AFULL_DEF,
   parameter bit COMMON_CLOCK = 1'b0
) (
   input  logic             wr_clk,
   input  logic             rd_clk,
   input  logic             rst_n,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] din,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             full,
   output logic             empty,
   output logic             afull
);

   // Pointers carry one extra wrap bit
   localparam int CW = DEPTH_LOG2 + 1;
   localparam int DEPTH = 1 << DEPTH_LOG2;
   localparam logic [CW-1:0] DEPTH_CNT = CW'(DEPTH);
   localparam logic [CW-1:0] AFULL_CNT = CW'(AFULL_THRESH);

   // Storage
   logic [WIDTH-1:0] mem [DEPTH];

   // Write domain pointers
   logic [CW-1:0] wr_bin;
   logic [CW-1:0] wr_bin_nxt;
   logic [CW-1:0] wr_gray;
   logic [CW-1:0] wr_count;
   logic          wr_inc;

   // Read domain pointers
   logic [CW-1:0] rd_bin;
   logic [CW-1:0] rd_bin_nxt;
   logic [CW-1:0] rd_gray;
   logic          rd_inc;

   // Pointers as seen from the opposite side
   logic [CW-1:0] wr_gray_rd;
   logic [CW-1:0] rd_gray_wr;

   function automatic logic [CW-1:0] gray2bin(input logic [CW-1:0] g);
      logic [CW-1:0] b;
      b[CW-1] = g[CW-1];
      for (int i = CW - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Write side
   assign wr_inc     = wr_en && !full;
   assign wr_bin_nxt = wr_bin + CW'(wr_inc);

   always_ff @(posedge wr_clk) begin
      if (!rst_n) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else begin
         wr_bin  <= wr_bin_nxt;
         wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
      end
   end

   always_ff @(posedge wr_clk) begin
      if (wr_inc) begin
         mem[wr_bin[DEPTH_LOG2-1:0]] <= din;
      end
   end

   // Fill level against the synchronized read pointer
   // pessimistic by the sync delay, never optimistic
   assign wr_count = wr_bin - gray2bin(rd_gray_wr);
   assign full     = (wr_count == DEPTH_CNT);
   assign afull    = (wr_count >= AFULL_CNT);

   // Read side
   assign rd_inc     = rd_en && !empty;
   assign rd_bin_nxt = rd_bin + CW'(rd_inc);

   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else begin
         rd_bin  <= rd_bin_nxt;
         rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      end
   end

   // First word fall through
   assign dout  = mem[rd_bin[DEPTH_LOG2-1:0]];
   assign empty = (rd_gray == wr_gray_rd);

   generate
      if (COMMON_CLOCK) begin : g_common
         // Shared clock so no synchronizers
         assign wr_gray_rd = wr_gray;
         assign rd_gray_wr = rd_gray;
      end else begin : g_dual
         logic [CW-1:0] wr_gray_m;
         logic [CW-1:0] wr_gray_s;
         logic [CW-1:0] rd_gray_m;
         logic [CW-1:0] rd_gray_s;

         // Two stage sync into the read domain
         always_ff @(posedge rd_clk) begin
            if (!rst_n) begin
               wr_gray_m <= '0;
               wr_gray_s <= '0;
            end else begin
               wr_gray_m <= wr_gray;
               wr_gray_s <= wr_gray_m;
            end
         end

         // Two stage sync into the write domain
         always_ff @(posedge wr_clk) begin
            if (!rst_n) begin
               rd_gray_m <= '0;
               rd_gray_s <= '0;
            end else begin
               rd_gray_m <= rd_gray;
               rd_gray_s <= rd_gray_m;
            end
         end

         assign wr_gray_rd = wr_gray_s;
         assign rd_gray_wr = rd_gray_s;
      end
   endgenerate

   // Producer must respect full
   a_no_overflow: assert property (@(posedge wr_clk) disable iff (!rst_n)
      wr_en |-> !full);

   // Consumer must respect empty
   a_no_underflow: assert property (@(posedge rd_clk) disable iff (!rst_n)
      rd_en |-> !empty);

endmodule

// ==== src/ifm_pkg.sv ====
package ifm_pkg;

   // Frame payload per beat
   localparam int DATA_W = 64;

   // One keep bit per payload byte
   localparam int KEEP_W = DATA_W / 8;

   // FIFO word layout
   // last flag on top, keep in the middle, data at the bottom
   localparam int WORD_W = DATA_W + KEEP_W + 1;

   // Keep field starts right above the data
   localparam int KEEP_LSB = DATA_W;

   // Last flag is the top bit of the word
   localparam int LAST_BIT = KEEP_LSB + KEEP_W;

   // Data and good FIFO depth, 1024 words
   localparam int DEPTH_LOG2_DEF = 10;

   // Almost full level in words
   // leaves room for a max size frame already in progress
   localparam int AFULL_DEF = 700;

   // Verdict FIFO depth, 256 entries
   localparam int INFO_LOG2_DEF = 8;

endpackage
